/* hdl/vga_regs_pkg.sv */
// ==============================
// VGA register block package
// Bus request, display settings and palette types, raster timing
// ==============================
`default_nettype none

package vga_regs_pkg;

    typedef struct packed {
        logic        access;
        logic        cs;
        logic [19:1] addr;
        logic [15:0] wdata;
        logic [1:0]  bytesel;
        logic        wr_en;
    } vga_bus_req_t;

    // Offsets decoded from address bits [4:1]
    typedef enum logic [3:0] {
        REG_AMCR       = 4'h0,
        REG_DAC_RD_IDX = 4'h3,
        REG_DAC        = 4'h4,
        REG_INDEX      = 4'ha,
        REG_MODE       = 4'hc,
        REG_STATUS     = 4'hd
    } vga_reg_e;

    typedef enum logic [3:0] {
        CRTC_CURSOR_START = 4'ha,
        CRTC_CURSOR_END   = 4'hb,
        CRTC_CURSOR_HI    = 4'he,
        CRTC_CURSOR_LO    = 4'hf
    } crtc_index_e;

    typedef struct packed {
        logic        cursor_enabled;
        logic        graphics_enabled;
        logic [3:0]  background_color;
        logic        bright_colors;
        logic        palette_sel;
        logic [14:0] cursor_pos;
        logic [2:0]  cursor_scan_start;
        logic [2:0]  cursor_scan_end;
        logic        color_256;
    } vga_display_cfg_t;

    typedef struct packed {
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
    } dac_entry_t;

    localparam logic [7:0] AMCR_256_COLOR = 8'h41;
    localparam int DAC_ENTRIES = 256;

    // Shortened raster, 40 clocks by 12 lines
    localparam int H_TOTAL      = 40;
    localparam int H_SYNC_START = 32;
    localparam int H_SYNC_LEN   = 4;
    localparam int V_TOTAL      = 12;
    localparam int V_SYNC_START = 10;
    localparam int V_SYNC_LEN   = 2;

endpackage

`default_nettype wire

/* hdl/bit_sync.sv */
// ==============================
// Two-flop synchronizer
// Brings a single level into the clk domain
// ==============================
`timescale 1ns/100ps
`default_nettype none

module bit_sync (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic d,
    output logic      q
);

    logic meta;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            meta <= 1'b0;
            q    <= 1'b0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end

endmodule

`default_nettype wire

/* hdl/mcp_sync.sv */
// ==============================
// Multi-cycle-path crossing
// Holds a word in domain A and loads it into domain B
// with a toggle request and a toggle acknowledge
// ==============================
`timescale 1ns/100ps
`default_nettype none

module mcp_sync #(
    parameter int              WIDTH     = 8,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  wire logic             reset,
    input  wire logic             clk_a,
    input  wire logic [WIDTH-1:0] a_datain,
    input  wire logic             a_send,
    output logic                  a_ready,
    input  wire logic             clk_b,
    output logic [WIDTH-1:0]      b_data,
    output logic                  b_load
);

    logic [WIDTH-1:0] a_data;
    logic             a_req;
    logic             a_ack;
    logic             b_req;
    logic             b_ack;

    // Domain A, the held word stays stable until the acknowledge returns
    always_ff @(posedge clk_a or posedge reset) begin
        if (reset)
            a_req <= 1'b0;
        else if (a_send && a_ready)
            a_req <= ~a_req;
    end

    always_ff @(posedge clk_a) begin
        if (a_send && a_ready)
            a_data <= a_datain;
    end

    assign a_ready = (a_req == a_ack);

    bit_sync req_sync (
        .clk   (clk_b),
        .reset (reset),
        .d     (a_req),
        .q     (b_req)
    );

    // Domain B, a request edge loads the word and flips the acknowledge
    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            b_ack  <= 1'b0;
            b_load <= 1'b0;
            b_data <= RESET_VAL;
        end else begin
            b_load <= (b_req != b_ack);
            b_ack  <= b_req;
            if (b_req != b_ack)
                b_data <= a_data;
        end
    end

    bit_sync ack_sync (
        .clk   (clk_a),
        .reset (reset),
        .d     (b_ack),
        .q     (a_ack)
    );

    // Sending while busy would change the word under domain B
    assert property (@(posedge clk_a) disable iff (reset) a_send |-> a_ready);

endmodule

`default_nettype wire

/* hdl/dac_palette_ram.sv */
// ==============================
// DAC palette RAM
// Bus read/write port and display read port on separate clocks
// ==============================
`timescale 1ns/100ps
`default_nettype none

module dac_palette_ram
    import vga_regs_pkg::*;
(
    input  wire logic       clk_a,
    input  wire logic [7:0] addr_a,
    input  wire dac_entry_t wdata_a,
    input  wire logic       wren_a,
    output dac_entry_t      rdata_a,
    input  wire logic       clk_b,
    input  wire logic [7:0] addr_b,
    output dac_entry_t      rdata_b
);

    dac_entry_t mem [DAC_ENTRIES];

    // Bus port, read returns the old entry on a write cycle
    always_ff @(posedge clk_a) begin
        if (wren_a)
            mem[addr_a] <= wdata_a;
        rdata_a <= mem[addr_a];
    end

    // Display port
    always_ff @(posedge clk_b) begin
        rdata_b <= mem[addr_b];
    end

    assert property (@(posedge clk_a) wren_a |-> !$isunknown(addr_a));

endmodule

`default_nettype wire

/* hdl/vga_sync_gen.sv */
// ==============================
// VGA sync generator
// Short raster hsync and vsync in vga_clk
// ==============================
`timescale 1ns/100ps
`default_nettype none

module vga_sync_gen
    import vga_regs_pkg::*;
(
    input  wire logic vga_clk,
    input  wire logic reset,
    output logic      hsync,
    output logic      vsync
);

    logic [$clog2(H_TOTAL)-1:0] col;
    logic [$clog2(V_TOTAL)-1:0] row;
    logic                       line_end;

    assign line_end = (col == H_TOTAL - 1);

    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else begin
            col <= line_end ? '0 : col + 1'b1;
            if (line_end)
                row <= (row == V_TOTAL - 1) ? '0 : row + 1'b1;
        end
    end

    // Registered sync windows
    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            hsync <= (col >= H_SYNC_START) && (col < H_SYNC_START + H_SYNC_LEN);
            vsync <= (row >= V_SYNC_START) && (row < V_SYNC_START + V_SYNC_LEN);
        end
    end

endmodule

`default_nettype wire

/* hdl/vga_registers.sv */
// ==============================
// VGA register block
// Bus register file, DAC sequencing, and transfer
// of display settings into vga_clk
// ==============================
`timescale 1ns/100ps
`default_nettype none

module vga_registers
    import vga_regs_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         vga_clk,
    input  wire logic         reset,
    input  wire vga_bus_req_t bus_req,
    output logic [15:0]       bus_rdata,
    output logic              bus_ack,
    input  wire logic         vga_hsync,
    input  wire logic         vga_vsync,
    input  wire logic [7:0]   vga_dac_idx,
    output dac_entry_t        vga_dac_rd,
    output vga_display_cfg_t  display_cfg
);

    vga_reg_e    reg_sel;
    logic        reg_access;
    logic        sel_index, sel_value, sel_mode, sel_color, sel_status;
    logic        sel_amcr, sel_dac_wr_idx, sel_dac_rd_idx, sel_dac;
    crtc_index_e active_index;
    crtc_index_e index;
    logic [7:0]  index_value;
    logic [15:0] rdata_next;

    logic [1:0]  cursor_mode;
    logic [2:0]  scan_start, scan_end;
    logic [14:0] cursor_pos;
    logic        display_enabled, text_enabled, graphics_enabled;
    logic        bright_colors, palette_sel, cursor_enabled;
    logic [3:0]  background_color;
    logic [7:0]  amcr;

    logic [7:0]  dac_wr_idx, dac_rd_idx;
    logic [1:0]  dac_wr_offs, dac_rd_offs;
    logic [11:0] dac_hold;
    logic        dac_wren;
    dac_entry_t  dac_rd;

    logic        hsync_s, vsync_s, send;
    logic        pos_ready, start_ready, end_ready, color_ready;
    logic [14:0] pos_xfer;
    logic [2:0]  start_xfer, end_xfer;
    logic [3:0]  color_xfer;
    logic        pos_load, start_load, end_load, color_load;
    logic [14:0] vga_cursor_pos;
    logic [2:0]  vga_scan_start, vga_scan_end;
    logic [3:0]  vga_background;
    logic        vga_cursor_en, vga_graphics, vga_bright, vga_palette_sel, vga_256;

    assign reg_access     = bus_req.access & bus_req.cs;
    assign reg_sel        = vga_reg_e'(bus_req.addr[4:1]);
    assign sel_index      = reg_access && reg_sel == REG_INDEX && bus_req.bytesel[0];
    assign sel_value      = reg_access && reg_sel == REG_INDEX && bus_req.bytesel[1];
    assign sel_mode       = reg_access && reg_sel == REG_MODE && bus_req.bytesel[0];
    assign sel_color      = reg_access && reg_sel == REG_MODE && bus_req.bytesel[1];
    assign sel_status     = reg_access && reg_sel == REG_STATUS && bus_req.bytesel[0];
    assign sel_amcr       = reg_access && reg_sel == REG_AMCR && bus_req.bytesel[0];
    assign sel_dac_wr_idx = reg_access && reg_sel == REG_DAC && bus_req.bytesel[0];
    assign sel_dac_rd_idx = reg_access && reg_sel == REG_DAC_RD_IDX && bus_req.bytesel[1];
    assign sel_dac        = reg_access && reg_sel == REG_DAC && bus_req.bytesel[1];

    // Index and value written together use the new index
    assign index = (sel_index && bus_req.wr_en) ? crtc_index_e'(bus_req.wdata[3:0])
                                                : active_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_index     <= crtc_index_e'(4'h0);
            cursor_mode      <= 2'b00;
            scan_start       <= 3'b000;
            scan_end         <= 3'b000;
            cursor_pos       <= 15'b0;
            display_enabled  <= 1'b0;
            text_enabled     <= 1'b0;
            graphics_enabled <= 1'b0;
            bright_colors    <= 1'b0;
            palette_sel      <= 1'b0;
            background_color <= 4'b0;
            amcr             <= 8'b0;
            cursor_enabled   <= 1'b0;
        end else begin
            cursor_enabled <= (cursor_mode != 2'b01);
            if (bus_req.wr_en) begin
                if (sel_index)
                    active_index <= index;
                if (sel_mode)
                    {display_enabled, graphics_enabled, text_enabled} <=
                        {bus_req.wdata[3], bus_req.wdata[1], bus_req.wdata[0]};
                if (sel_color)
                    {palette_sel, bright_colors, background_color} <= bus_req.wdata[13:8];
                if (sel_amcr)
                    amcr <= bus_req.wdata[7:0];
                if (sel_value) begin
                    case (index)
                        CRTC_CURSOR_START: {cursor_mode, scan_start} <=
                            {bus_req.wdata[13:12], bus_req.wdata[10:8]};
                        CRTC_CURSOR_END: scan_end <= bus_req.wdata[10:8];
                        CRTC_CURSOR_HI: cursor_pos[14:8] <= bus_req.wdata[14:8];
                        CRTC_CURSOR_LO: cursor_pos[7:0] <= bus_req.wdata[15:8];
                        default: ;
                    endcase
                end
            end
        end
    end

    // DAC index and component sequencing
    assign dac_wren = sel_dac && bus_req.wr_en && dac_wr_offs == 2'd2;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dac_wr_idx  <= 8'b0;
            dac_rd_idx  <= 8'b0;
            dac_wr_offs <= 2'd0;
            dac_rd_offs <= 2'd0;
        end else begin
            if (sel_dac_wr_idx && bus_req.wr_en) begin
                dac_wr_idx  <= bus_req.wdata[7:0];
                dac_wr_offs <= 2'd0;
            end
            if (sel_dac_rd_idx && bus_req.wr_en) begin
                dac_rd_idx  <= bus_req.wdata[15:8];
                dac_rd_offs <= 2'd0;
            end
            if (sel_dac && bus_req.wr_en) begin
                dac_wr_offs <= (dac_wr_offs == 2'd2) ? 2'd0 : dac_wr_offs + 2'd1;
                if (dac_wr_offs == 2'd2)
                    dac_wr_idx <= dac_wr_idx + 8'd1;
            end
            if (sel_dac && !bus_req.wr_en) begin
                dac_rd_offs <= (dac_rd_offs == 2'd2) ? 2'd0 : dac_rd_offs + 2'd1;
                if (dac_rd_offs == 2'd2)
                    dac_rd_idx <= dac_rd_idx + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_dac && bus_req.wr_en && dac_wr_offs != 2'd2)
            dac_hold <= {dac_hold[5:0], bus_req.wdata[13:8]};
    end

    dac_palette_ram palette (
        .clk_a   (clk),
        .addr_a  ((sel_dac && bus_req.wr_en) ? dac_wr_idx : dac_rd_idx),
        .wdata_a (dac_entry_t'({dac_hold, bus_req.wdata[13:8]})),
        .wren_a  (dac_wren),
        .rdata_a (dac_rd),
        .clk_b   (vga_clk),
        .addr_b  (vga_dac_idx),
        .rdata_b (vga_dac_rd)
    );

    always_comb begin
        case (index)
            CRTC_CURSOR_START: index_value = {2'b0, cursor_mode, 1'b0, scan_start};
            CRTC_CURSOR_END: index_value = {5'b0, scan_end};
            CRTC_CURSOR_HI: index_value = {2'b0, cursor_pos[13:8]};
            CRTC_CURSOR_LO: index_value = cursor_pos[7:0];
            default: index_value = 8'b0;
        endcase
    end

    always_comb begin
        rdata_next = 16'b0;
        if (!bus_req.wr_en) begin
            if (sel_index)
                rdata_next[7:0] = {4'b0, active_index};
            if (sel_mode)
                rdata_next[7:0] = {4'b0, display_enabled, 1'b0, graphics_enabled, text_enabled};
            if (sel_status)
                rdata_next[7:0] = {4'b0, vga_vsync, 2'b0, vsync_s | hsync_s};
            if (sel_amcr)
                rdata_next[7:0] = amcr;
            if (sel_value)
                rdata_next[15:8] = index_value;
            if (sel_color)
                rdata_next[15:8] = {2'b0, palette_sel, bright_colors, background_color};
            if (sel_dac) begin
                case (dac_rd_offs)
                    2'd0: rdata_next[15:8] = {2'b0, dac_rd.red};
                    2'd1: rdata_next[15:8] = {2'b0, dac_rd.green};
                    default: rdata_next[15:8] = {2'b0, dac_rd.blue};
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_rdata <= 16'b0;
            bus_ack   <= 1'b0;
        end else begin
            bus_rdata <= rdata_next;
            bus_ack   <= reg_access;
        end
    end

    // Sync inputs into clk, single-bit settings into vga_clk
    bit_sync hsync_sync (.clk(clk), .reset(reset), .d(vga_hsync), .q(hsync_s));
    bit_sync vsync_sync (.clk(clk), .reset(reset), .d(vga_vsync), .q(vsync_s));
    bit_sync gfx_sync (.clk(vga_clk), .reset(reset), .d(graphics_enabled), .q(vga_graphics));
    bit_sync bright_sync (.clk(vga_clk), .reset(reset), .d(bright_colors), .q(vga_bright));
    bit_sync cursor_sync (.clk(vga_clk), .reset(reset), .d(cursor_enabled), .q(vga_cursor_en));
    bit_sync pal_sync (.clk(vga_clk), .reset(reset), .d(palette_sel), .q(vga_palette_sel));
    bit_sync c256_sync (.clk(vga_clk), .reset(reset), .d(amcr == AMCR_256_COLOR), .q(vga_256));

    // One send per ready window, only while vsync is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            send <= 1'b0;
        else
            send <= pos_ready && start_ready && end_ready && color_ready && vsync_s && !send;
    end

    mcp_sync #(.WIDTH(15), .RESET_VAL(15'b0)) pos_mcp (
        .reset(reset), .clk_a(clk), .a_datain(cursor_pos), .a_send(send),
        .a_ready(pos_ready), .clk_b(vga_clk), .b_data(pos_xfer), .b_load(pos_load)
    );
    mcp_sync #(.WIDTH(3), .RESET_VAL(3'b0)) start_mcp (
        .reset(reset), .clk_a(clk), .a_datain(scan_start), .a_send(send),
        .a_ready(start_ready), .clk_b(vga_clk), .b_data(start_xfer), .b_load(start_load)
    );
    mcp_sync #(.WIDTH(3), .RESET_VAL(3'b0)) end_mcp (
        .reset(reset), .clk_a(clk), .a_datain(scan_end), .a_send(send),
        .a_ready(end_ready), .clk_b(vga_clk), .b_data(end_xfer), .b_load(end_load)
    );
    mcp_sync #(.WIDTH(4), .RESET_VAL(4'b0)) color_mcp (
        .reset(reset), .clk_a(clk), .a_datain(background_color), .a_send(send),
        .a_ready(color_ready), .clk_b(vga_clk), .b_data(color_xfer), .b_load(color_load)
    );

    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            vga_cursor_pos <= 15'b0;
            vga_scan_start <= 3'b0;
            vga_scan_end   <= 3'b0;
            vga_background <= 4'b0;
        end else begin
            if (pos_load)
                vga_cursor_pos <= pos_xfer;
            if (start_load)
                vga_scan_start <= start_xfer;
            if (end_load)
                vga_scan_end <= end_xfer;
            if (color_load)
                vga_background <= color_xfer;
        end
    end

    always_comb begin
        display_cfg.cursor_enabled    = vga_cursor_en;
        display_cfg.graphics_enabled  = vga_graphics;
        display_cfg.background_color  = vga_background;
        display_cfg.bright_colors     = vga_bright;
        display_cfg.palette_sel       = vga_palette_sel;
        display_cfg.cursor_pos        = vga_cursor_pos;
        display_cfg.cursor_scan_start = vga_scan_start;
        display_cfg.cursor_scan_end   = vga_scan_end;
        display_cfg.color_256         = vga_256;
    end

    assert property (@(posedge clk) disable iff (reset)
                     dac_wr_offs != 2'd3 && dac_rd_offs != 2'd3);

endmodule

`default_nettype wire

/* hdl/vga_regs_top.sv */
// ==============================
// VGA register subsystem top
// Register block and sync generator
// ==============================
`timescale 1ns/100ps
`default_nettype none

module vga_regs_top
    import vga_regs_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         vga_clk,
    input  wire logic         reset,
    input  wire vga_bus_req_t bus_req,
    output logic [15:0]       bus_rdata,
    output logic              bus_ack,
    input  wire logic [7:0]   dac_idx,
    output dac_entry_t        dac_rd,
    output vga_display_cfg_t  display_cfg,
    output logic              hsync,
    output logic              vsync
);

    vga_registers regs (
        .clk         (clk),
        .vga_clk     (vga_clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .vga_hsync   (hsync),
        .vga_vsync   (vsync),
        .vga_dac_idx (dac_idx),
        .vga_dac_rd  (dac_rd),
        .display_cfg (display_cfg)
    );

    vga_sync_gen sync_gen (
        .vga_clk (vga_clk),
        .reset   (reset),
        .hsync   (hsync),
        .vsync   (vsync)
    );

endmodule

`default_nettype wire

/* verification/tb_vga_regs.sv */
// ==============================
// VGA register block testbench
// Directed bus, crossing, palette and status tests
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tb_vga_regs
    import vga_regs_pkg::*;
();

    localparam int NUM_TESTS    = 7;
    localparam int CLK_NS       = 20;
    localparam int VGA_NS       = 30;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_NS     = H_TOTAL * V_TOTAL * VGA_NS;
    localparam int WATCHDOG_NS  = NUM_TESTS * 4 * FRAME_NS + RESET_CYCLES * CLK_NS;
    localparam int NUM_PAL      = 4;

    logic             clk;
    logic             vga_clk;
    logic             reset;
    vga_bus_req_t     bus_req;
    logic [15:0]      bus_rdata;
    logic             bus_ack;
    logic [7:0]       dac_idx;
    dac_entry_t       dac_rd;
    vga_display_cfg_t display_cfg;
    logic             hsync;
    logic             vsync;

    int               mismatches;
    int               failures;
    int               ack_cycles;
    logic [7:0]       amcr_written;
    vga_display_cfg_t cfg_exp;
    // vsync as seen at the last three clk edges
    logic [2:0]       vsync_hist;

    vga_regs_top i_dut (
        .clk         (clk),
        .vga_clk     (vga_clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .dac_idx     (dac_idx),
        .dac_rd      (dac_rd),
        .display_cfg (display_cfg),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    always #(CLK_NS / 2) clk = ~clk;
    always #(VGA_NS / 2) vga_clk = ~vga_clk;

    always @(posedge clk) begin
        vsync_hist <= {vsync_hist[1:0], vsync};
    end

    task automatic check_rdata(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cfg(input vga_display_cfg_t got, input vga_display_cfg_t exp,
                             input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s are %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dac(input dac_entry_t got, input dac_entry_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // One request pulse, then wait for ack
    task automatic pulse_request(input vga_reg_e offs, input logic [1:0] bsel, input logic wr,
                                 input logic [15:0] wdata, output logic [15:0] rdata);
        @(posedge clk);
        #2;
        bus_req.access  = 1'b1;
        bus_req.cs      = 1'b1;
        bus_req.addr    = {15'b0, offs};
        bus_req.wdata   = wdata;
        bus_req.bytesel = bsel;
        bus_req.wr_en   = wr;
        @(posedge clk);
        #2;
        bus_req    = '0;
        ack_cycles = 1;
        while (bus_ack !== 1'b1 && ack_cycles < 2) begin
            @(posedge clk);
            #2;
            ack_cycles++;
        end
        if (bus_ack !== 1'b1) begin
            failures++;
            $display("No bus ack within two cycles of the request to offset %h at %0t ns",
                     offs, $time);
        end
        rdata = bus_rdata;
    endtask

    task automatic bus_write(input vga_reg_e offs, input logic [1:0] bsel,
                             input logic [15:0] data);
        logic [15:0] unused;
        pulse_request(offs, bsel, 1'b1, data, unused);
    endtask

    task automatic bus_read(input vga_reg_e offs, input logic [1:0] bsel,
                            output logic [15:0] data);
        pulse_request(offs, bsel, 1'b0, 16'h0000, data);
    endtask

    task automatic write_crtc(input crtc_index_e idx, input logic [7:0] value);
        bus_write(REG_INDEX, 2'b01, {12'h000, idx});
        bus_write(REG_INDEX, 2'b10, {value, 8'h00});
    endtask

    task automatic expect_single_cycle_ack(input string what);
        if (ack_cycles != 1) begin
            failures++;
            $display("Ack for the %s read came %0d cycles after the request", what, ack_cycles);
        end
    endtask

    task automatic wait_vsync_start();
        int n;
        n = 0;
        while (vsync !== 1'b0 && n < 2 * H_TOTAL * V_TOTAL) begin
            @(posedge vga_clk);
            #2;
            n++;
        end
        while (vsync !== 1'b1 && n < 2 * H_TOTAL * V_TOTAL) begin
            @(posedge vga_clk);
            #2;
            n++;
        end
        if (vsync !== 1'b1) begin
            failures++;
            $display("vsync did not start within two frames");
        end
    endtask

    // Counts vga_clk cycles until hsync reaches the given level
    task automatic count_hsync_until(input logic level, output int cycles);
        cycles = 0;
        while (hsync !== level && cycles < 2 * H_TOTAL) begin
            @(posedge vga_clk);
            #2;
            cycles++;
        end
    endtask

    task automatic reset_defaults();
        logic [15:0] rd;
        if (bus_ack !== 1'b0) begin
            failures++;
            $display("bus_ack is high right after reset");
        end
        check_cfg(display_cfg, '0, "display settings after reset");
        bus_read(REG_MODE, 2'b01, rd);
        expect_single_cycle_ack("mode");
        check_rdata(rd, 16'h0000, "mode after reset");
        bus_read(REG_INDEX, 2'b01, rd);
        expect_single_cycle_ack("index");
        check_rdata(rd, 16'h0000, "index after reset");
        bus_read(REG_MODE, 2'b10, rd);
        expect_single_cycle_ack("colour");
        check_rdata(rd, 16'h0000, "colour after reset");
    endtask

    task automatic register_readback();
        logic [15:0] wr_val;
        logic [7:0]  v;
        logic [15:0] rd;
        wr_val = 16'($urandom);
        bus_write(REG_INDEX, 2'b01, wr_val);
        bus_read(REG_INDEX, 2'b01, rd);
        check_rdata(rd, {12'h000, wr_val[3:0]}, "CRTC index");
        wr_val = 16'($urandom);
        bus_write(REG_MODE, 2'b01, wr_val);
        bus_read(REG_MODE, 2'b01, rd);
        check_rdata(rd, {12'h000, wr_val[3], 1'b0, wr_val[1:0]}, "mode");
        wr_val = 16'($urandom);
        bus_write(REG_MODE, 2'b10, wr_val);
        bus_read(REG_MODE, 2'b10, rd);
        check_rdata(rd, {2'b00, wr_val[13:8], 8'h00}, "colour");
        wr_val = 16'($urandom);
        bus_write(REG_AMCR, 2'b01, wr_val);
        amcr_written = wr_val[7:0];
        bus_read(REG_AMCR, 2'b01, rd);
        check_rdata(rd, {8'h00, wr_val[7:0]}, "AMCR");
        // Value register follows the CRTC index
        v = 8'($urandom);
        write_crtc(CRTC_CURSOR_START, v);
        bus_read(REG_INDEX, 2'b10, rd);
        check_rdata(rd, {2'b00, v[5:4], 1'b0, v[2:0], 8'h00}, "cursor start");
        v = 8'($urandom);
        write_crtc(CRTC_CURSOR_HI, v);
        bus_read(REG_INDEX, 2'b10, rd);
        check_rdata(rd, {2'b00, v[5:0], 8'h00}, "cursor high");
    endtask

    task automatic cursor_transfer();
        logic [7:0]  start_val;
        logic [7:0]  end_val;
        logic [7:0]  color_val;
        logic [7:0]  mode_val;
        logic [14:0] pos;
        start_val = 8'($urandom);
        end_val   = 8'($urandom);
        color_val = 8'($urandom);
        mode_val  = 8'($urandom);
        pos       = 15'($urandom);
        write_crtc(CRTC_CURSOR_START, start_val);
        write_crtc(CRTC_CURSOR_END, end_val);
        write_crtc(CRTC_CURSOR_HI, {1'b0, pos[14:8]});
        write_crtc(CRTC_CURSOR_LO, pos[7:0]);
        bus_write(REG_MODE, 2'b10, {color_val, 8'h00});
        bus_write(REG_MODE, 2'b01, {8'h00, mode_val});
        cfg_exp.cursor_enabled    = (start_val[5:4] != 2'b01);
        cfg_exp.graphics_enabled  = mode_val[1];
        cfg_exp.background_color  = color_val[3:0];
        cfg_exp.bright_colors     = color_val[4];
        cfg_exp.palette_sel       = color_val[5];
        cfg_exp.cursor_pos        = pos;
        cfg_exp.cursor_scan_start = start_val[2:0];
        cfg_exp.cursor_scan_end   = end_val[2:0];
        cfg_exp.color_256         = (amcr_written == AMCR_256_COLOR);
        wait_vsync_start();
        repeat (10) @(posedge vga_clk);
        #2;
        check_cfg(display_cfg, cfg_exp, "display settings after vsync");
    endtask

    task automatic color_256_select();
        logic [7:0] other;
        bus_write(REG_AMCR, 2'b01, {8'h00, AMCR_256_COLOR});
        amcr_written      = AMCR_256_COLOR;
        cfg_exp.color_256 = 1'b1;
        // Two synchronizer edges and one spare
        repeat (3) @(posedge vga_clk);
        #2;
        check_cfg(display_cfg, cfg_exp, "display settings with 256 colours");
        other = 8'($urandom);
        if (other == AMCR_256_COLOR)
            other = 8'h00;
        bus_write(REG_AMCR, 2'b01, {8'h00, other});
        amcr_written      = other;
        cfg_exp.color_256 = 1'b0;
        repeat (3) @(posedge vga_clk);
        #2;
        check_cfg(display_cfg, cfg_exp, "display settings without 256 colours");
    endtask

    task automatic palette_sequencing();
        dac_entry_t  entries [NUM_PAL];
        logic [7:0]  base;
        logic [15:0] rd;
        int          i;
        base = 8'($urandom);
        bus_write(REG_DAC, 2'b01, {8'h00, base});
        for (i = 0; i < NUM_PAL; i++) begin
            entries[i] = 18'($urandom);
            bus_write(REG_DAC, 2'b10, {2'b00, entries[i].red, 8'h00});
            bus_write(REG_DAC, 2'b10, {2'b00, entries[i].green, 8'h00});
            bus_write(REG_DAC, 2'b10, {2'b00, entries[i].blue, 8'h00});
        end
        bus_write(REG_DAC_RD_IDX, 2'b10, {base, 8'h00});
        for (i = 0; i < NUM_PAL; i++) begin
            bus_read(REG_DAC, 2'b10, rd);
            check_rdata(rd, {2'b00, entries[i].red, 8'h00}, "palette red");
            bus_read(REG_DAC, 2'b10, rd);
            check_rdata(rd, {2'b00, entries[i].green, 8'h00}, "palette green");
            bus_read(REG_DAC, 2'b10, rd);
            check_rdata(rd, {2'b00, entries[i].blue, 8'h00}, "palette blue");
        end
        // Display port, one vga_clk after the index
        for (i = 0; i < NUM_PAL; i++) begin
            @(posedge vga_clk);
            #2;
            dac_idx = 8'(base + i);
            @(posedge vga_clk);
            #2;
            check_dac(dac_rd, entries[i], "display palette read");
        end
    endtask

    task automatic status_reads();
        logic [15:0] rd;
        time         t_end;
        int          high_reads;
        high_reads = 0;
        t_end      = $time + FRAME_NS;
        while ($time < t_end) begin
            bus_read(REG_STATUS, 2'b01, rd);
            check_rdata(rd & 16'hfff6, 16'h0000, "status unused bits");
            if (vsync_hist === 3'b111) begin
                high_reads++;
                check_rdata(rd & 16'h0008, 16'h0008, "status vsync bit");
            end
        end
        if (high_reads == 0) begin
            failures++;
            $display("No status read fell inside a vsync pulse");
        end
    endtask

    // Line timing seen on the hsync port
    task automatic hsync_timing();
        int skip;
        int high_len;
        int low_len;
        count_hsync_until(1'b0, skip);
        count_hsync_until(1'b1, skip);
        count_hsync_until(1'b0, high_len);
        count_hsync_until(1'b1, low_len);
        check_count(high_len, H_SYNC_LEN, "hsync pulse width");
        check_count(high_len + low_len, H_TOTAL, "hsync period");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned seed_word;
        seed_word    = $urandom(96158);
        clk          = 1'b0;
        vga_clk      = 1'b0;
        reset        = 1'b1;
        bus_req      = '0;
        dac_idx      = 8'h00;
        mismatches   = 0;
        failures     = 0;
        ack_cycles   = 0;
        amcr_written = 8'h00;
        cfg_exp      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        reset_defaults();
        register_readback();
        cursor_transfer();
        color_256_select();
        palette_sequencing();
        status_reads();
        hsync_timing();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/vga_regs_pkg.sv
hdl/bit_sync.sv
hdl/mcp_sync.sv
hdl/dac_palette_ram.sv
hdl/vga_sync_gen.sv
hdl/vga_registers.sv
hdl/vga_regs_top.sv
verification/tb_vga_regs.sv

/* Bender.yml */
package:
  name: vga_regs

sources:
  - hdl/vga_regs_pkg.sv
  - hdl/bit_sync.sv
  - hdl/mcp_sync.sv
  - hdl/dac_palette_ram.sv
  - hdl/vga_sync_gen.sv
  - hdl/vga_registers.sv
  - hdl/vga_regs_top.sv
  - target: test
    files:
      - verification/tb_vga_regs.sv
